/* sim.f */
hdl/core_pkg.sv
hdl/control_unit.sv
hdl/register_file.sv
hdl/decode_registers.sv
hdl/execute_unit.sv
hdl/decode_execute_top.sv
test/clock_gen.sv
test/decode_execute_properties.sv
test/decode_execute_tb.sv

/* Makefile */
TOP := decode_execute_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "run FAILED, see $(LOG)"; exit 1; fi
	@grep -q "Simulation passed" $(LOG) || (echo "run ended without a pass line"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* test/decode_execute_tb.sv */
// Testbench for the decode/execute slice
// Table driven stimulus, shadow register model and an in-order writeback monitor

module decode_execute_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          RESET_CYCLES = 4;
  localparam int          DRIVE_DELAY  = 1;
  localparam int unsigned SEED         = 32'hcd04_9e9c;
  localparam logic [6:0]  F7_BASE      = 7'b000_0000;

  logic                                 clk;
  logic                                 rst_n;
  core_pkg::instr_u                     instr;
  logic                                 instr_valid;
  logic                                 instr_ready;
  logic                                 wb_en;
  logic [core_pkg::REG_INDEX_WIDTH-1:0] wb_addr;
  logic [core_pkg::WORD_WIDTH-1:0]      wb_data;

  // Stimulus table, one entry per index
  string            test_name [$];
  core_pkg::instr_u test_word [$];
  bit               test_wb   [$];

  // Writebacks still owed by the DUT in program order
  string                                exp_name [$];
  logic [core_pkg::REG_INDEX_WIDTH-1:0] exp_addr [$];
  logic [core_pkg::WORD_WIDTH-1:0]      exp_data [$];

  logic [core_pkg::WORD_WIDTH-1:0] shadow [core_pkg::NUM_REGS];
  int cycle_count   = 0;
  int timeout_limit = 0;
  bit ready_dropped = 1'b0;

  clock_gen u_clock_gen (
    .clk (clk)
  );

  decode_execute_top u_decode_execute_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr       (instr),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .wb_en       (wb_en),
    .wb_addr     (wb_addr),
    .wb_data     (wb_data)
  );

  task automatic end_with_failure();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("error: %s expected %0b actual %0b", name, expected, actual);
      end_with_failure();
    end
  endtask

  task automatic check_index(input string name,
                             input logic [core_pkg::REG_INDEX_WIDTH-1:0] expected,
                             input logic [core_pkg::REG_INDEX_WIDTH-1:0] actual);
    if (actual !== expected)
    begin
      $display("error: %s expected x%0d actual x%0d", name, expected, actual);
      end_with_failure();
    end
  endtask

  task automatic check_word(input string name,
                            input logic [core_pkg::WORD_WIDTH-1:0] expected,
                            input logic [core_pkg::WORD_WIDTH-1:0] actual);
    if (actual !== expected)
    begin
      $display("error: %s expected %h actual %h", name, expected, actual);
      end_with_failure();
    end
  endtask

  function automatic core_pkg::instr_u r_type_word(input logic [6:0] funct7,
                                                   input logic [4:0] rs2,
                                                   input logic [4:0] rs1,
                                                   input logic [2:0] funct3,
                                                   input logic [4:0] rd);
    core_pkg::instr_u w;
    w.r.funct7 = funct7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = funct3;
    w.r.rd     = rd;
    w.r.opcode = core_pkg::OPCODE_OP;
    return w;
  endfunction

  function automatic core_pkg::instr_u i_type_word(input logic [11:0] imm12,
                                                   input logic [4:0]  rs1,
                                                   input logic [2:0]  funct3,
                                                   input logic [4:0]  rd);
    core_pkg::instr_u w;
    w.i.imm12  = imm12;
    w.i.rs1    = rs1;
    w.i.funct3 = funct3;
    w.i.rd     = rd;
    w.i.opcode = core_pkg::OPCODE_OP_IMM;
    return w;
  endfunction

  function automatic logic [11:0] random_imm12();
    logic [31:0] r;
    r = $urandom();
    return r[11:0];
  endfunction

  task automatic add_entry(input string name, input core_pkg::instr_u word, input bit wb);
    test_name.push_back(name);
    test_word.push_back(word);
    test_wb.push_back(wb);
  endtask

  task automatic build_table();
    core_pkg::instr_u w;
    // ADDI loads with negative and random immediates
    add_entry("addi_x1", i_type_word(12'h123, 5'd0, core_pkg::FUNCT3_ADD, 5'd1), 1'b1);
    add_entry("addi_x2_neg", i_type_word(12'hffb, 5'd0, core_pkg::FUNCT3_ADD, 5'd2), 1'b1);
    add_entry("addi_x3_rand", i_type_word(random_imm12(), 5'd0, core_pkg::FUNCT3_ADD, 5'd3), 1'b1);
    add_entry("addi_x4_rand", i_type_word(random_imm12(), 5'd0, core_pkg::FUNCT3_ADD, 5'd4), 1'b1);
    add_entry("addi_x5_max", i_type_word(12'h7ff, 5'd0, core_pkg::FUNCT3_ADD, 5'd5), 1'b1);
    add_entry("addi_x6_min", i_type_word(12'h800, 5'd0, core_pkg::FUNCT3_ADD, 5'd6), 1'b1);
    // Register-register and immediate logic ops
    add_entry("add_x7", r_type_word(F7_BASE, 5'd2, 5'd1, core_pkg::FUNCT3_ADD, 5'd7), 1'b1);
    add_entry("sub_x8", r_type_word(core_pkg::FUNCT7_SUB, 5'd4, 5'd3, core_pkg::FUNCT3_ADD, 5'd8), 1'b1);
    add_entry("and_x9", r_type_word(F7_BASE, 5'd6, 5'd5, core_pkg::FUNCT3_AND, 5'd9), 1'b1);
    add_entry("or_x10", r_type_word(F7_BASE, 5'd3, 5'd1, core_pkg::FUNCT3_OR, 5'd10), 1'b1);
    add_entry("xor_x11", r_type_word(F7_BASE, 5'd4, 5'd2, core_pkg::FUNCT3_XOR, 5'd11), 1'b1);
    add_entry("andi_x12", i_type_word(random_imm12(), 5'd3, core_pkg::FUNCT3_AND, 5'd12), 1'b1);
    add_entry("ori_x13", i_type_word(12'h0f0, 5'd4, core_pkg::FUNCT3_OR, 5'd13), 1'b1);
    add_entry("xori_x14", i_type_word(12'hfff, 5'd1, core_pkg::FUNCT3_XOR, 5'd14), 1'b1);
    // Each word needs the result of the one before it
    add_entry("dep_addi_x15", i_type_word(12'h007, 5'd1, core_pkg::FUNCT3_ADD, 5'd15), 1'b1);
    add_entry("dep_add_x16", r_type_word(F7_BASE, 5'd15, 5'd15, core_pkg::FUNCT3_ADD, 5'd16), 1'b1);
    add_entry("dep_sub_x17", r_type_word(core_pkg::FUNCT7_SUB, 5'd15, 5'd16, core_pkg::FUNCT3_ADD, 5'd17), 1'b1);
    add_entry("dep_xori_x17", i_type_word(random_imm12(), 5'd17, core_pkg::FUNCT3_XOR, 5'd17), 1'b1);
    // Multiplier with dependent and independent followers
    add_entry("mul_x20", r_type_word(core_pkg::FUNCT7_MULDIV, 5'd4, 5'd3, core_pkg::FUNCT3_ADD, 5'd20), 1'b1);
    add_entry("mul_dep_x21", r_type_word(F7_BASE, 5'd1, 5'd20, core_pkg::FUNCT3_ADD, 5'd21), 1'b1);
    add_entry("mul_neg_x22", r_type_word(core_pkg::FUNCT7_MULDIV, 5'd6, 5'd2, core_pkg::FUNCT3_ADD, 5'd22), 1'b1);
    add_entry("mul_indep_x23", i_type_word(12'h001, 5'd5, core_pkg::FUNCT3_ADD, 5'd23), 1'b1);
    add_entry("mul_chain_x24", r_type_word(core_pkg::FUNCT7_MULDIV, 5'd23, 5'd22, core_pkg::FUNCT3_ADD, 5'd24), 1'b1);
    add_entry("mul_back_x25", r_type_word(core_pkg::FUNCT7_MULDIV, 5'd7, 5'd24, core_pkg::FUNCT3_ADD, 5'd25), 1'b1);
    // No writeback expected from these
    add_entry("x0_addi", i_type_word(12'h005, 5'd1, core_pkg::FUNCT3_ADD, 5'd0), 1'b0);
    add_entry("x0_add", r_type_word(F7_BASE, 5'd2, 5'd1, core_pkg::FUNCT3_ADD, 5'd0), 1'b0);
    add_entry("nop_word", core_pkg::NOP_INSTRUCTION, 1'b0);
    w = i_type_word(12'h010, 5'd1, core_pkg::FUNCT3_ADD, 5'd9);
    w.i.opcode = 7'b000_0011;
    add_entry("unknown_load", w, 1'b0);
    w = i_type_word(12'h345, 5'd0, core_pkg::FUNCT3_ADD, 5'd10);
    w.i.opcode = 7'b011_0111;
    add_entry("unknown_lui", w, 1'b0);
    add_entry("unsupported_funct3", i_type_word(12'h001, 5'd1, 3'b010, 5'd11), 1'b0);
    // x0 still reads as zero and earlier targets stay untouched
    add_entry("read_x0_add", r_type_word(F7_BASE, 5'd2, 5'd0, core_pkg::FUNCT3_ADD, 5'd26), 1'b1);
    add_entry("read_x0_ori", i_type_word(12'h000, 5'd0, core_pkg::FUNCT3_OR, 5'd27), 1'b1);
    add_entry("keep_x9", r_type_word(F7_BASE, 5'd0, 5'd9, core_pkg::FUNCT3_ADD, 5'd28), 1'b1);
    add_entry("x0_mul", r_type_word(core_pkg::FUNCT7_MULDIV, 5'd2, 5'd1, core_pkg::FUNCT3_ADD, 5'd0), 1'b0);
    add_entry("after_x0_mul", r_type_word(F7_BASE, 5'd26, 5'd28, core_pkg::FUNCT3_ADD, 5'd29), 1'b1);
  endtask

  // Shadow model of the ISA rules that queues the expected writeback
  task automatic model_instruction(input string name, input core_pkg::instr_u w,
                                   output bit writes);
    logic [core_pkg::WORD_WIDTH-1:0] a;
    logic [core_pkg::WORD_WIDTH-1:0] b;
    logic [core_pkg::WORD_WIDTH-1:0] value;
    logic signed [11:0]              imm_s;
    bit                              known;
    a     = shadow[w.r.rs1];
    b     = shadow[w.r.rs2];
    value = '0;
    known = 1'b1;
    if (w.r.opcode == core_pkg::OPCODE_OP)
    begin
      case (w.r.funct3)
        core_pkg::FUNCT3_ADD:
        begin
          if (w.r.funct7 == core_pkg::FUNCT7_MULDIV)
            value = a * b;
          else if (w.r.funct7 == core_pkg::FUNCT7_SUB)
            value = a - b;
          else
            value = a + b;
        end
        core_pkg::FUNCT3_AND: value = a & b;
        core_pkg::FUNCT3_OR:  value = a | b;
        core_pkg::FUNCT3_XOR: value = a ^ b;
        default:              known = 1'b0;
      endcase
    end
    else if (w.i.opcode == core_pkg::OPCODE_OP_IMM)
    begin
      // Immediate taken as a signed 12-bit value and widened
      imm_s = w.i.imm12;
      b     = 32'(imm_s);
      case (w.i.funct3)
        core_pkg::FUNCT3_ADD: value = a + b;
        core_pkg::FUNCT3_AND: value = a & b;
        core_pkg::FUNCT3_OR:  value = a | b;
        core_pkg::FUNCT3_XOR: value = a ^ b;
        default:              known = 1'b0;
      endcase
    end
    else
    begin
      known = 1'b0;
    end
    writes = known && (w.r.rd != '0);
    if (writes)
    begin
      shadow[w.r.rd] = value;
      exp_name.push_back(name);
      exp_addr.push_back(w.r.rd);
      exp_data.push_back(value);
    end
  endtask

  // Called just after a rising edge and returns just after the accepting edge
  task automatic drive_entry(input int idx);
    bit writes;
    model_instruction(test_name[idx], test_word[idx], writes);
    if (writes != test_wb[idx])
    begin
      $display("table entry %s disagrees with the reference model on writeback",
               test_name[idx]);
      end_with_failure();
    end
    instr       = test_word[idx];
    instr_valid = 1'b1;
    // Ready settles between edges so it is looked at mid-cycle
    @(negedge clk);
    while (!instr_ready)
    begin
      ready_dropped = 1'b1;
      @(negedge clk);
    end
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  // Writebacks are compared against the queue head in program order
  always @(negedge clk)
  begin
    if (rst_n && wb_en)
    begin
      if (exp_addr.size() == 0)
      begin
        $display("writeback to x%0d arrived with no instruction pending", wb_addr);
        end_with_failure();
      end
      else
      begin
        check_index(exp_name[0], exp_addr[0], wb_addr);
        check_word(exp_name[0], exp_data[0], wb_data);
        void'(exp_name.pop_front());
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (timeout_limit > 0 && cycle_count >= timeout_limit)
    begin
      $display("timeout, the run did not finish within %0d cycles", timeout_limit);
      end_with_failure();
    end
  end

  initial
  begin
    void'($urandom(SEED));
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = core_pkg::NOP_INSTRUCTION;
    for (int r = 0; r < core_pkg::NUM_REGS; r++)
      shadow[r] = '0;
    build_table();
    timeout_limit = test_word.size() * (core_pkg::MUL_CYCLES + 4) + 50;

    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    @(negedge clk);
    check_flag("reset_instr_ready", 1'b1, instr_ready);
    check_flag("reset_wb_en", 1'b0, wb_en);
    @(posedge clk);
    #DRIVE_DELAY;

    for (int i = 0; i < test_word.size(); i++)
      drive_entry(i);
    instr_valid = 1'b0;
    instr       = core_pkg::NOP_INSTRUCTION;

    // At most two items are still in flight once the last word is taken
    for (int c = 0; c < 2 * (core_pkg::MUL_CYCLES + 4) && exp_addr.size() != 0; c++)
      @(negedge clk);
    // Quiet window where a stray writeback would still be caught
    repeat (core_pkg::MUL_CYCLES + 4) @(negedge clk);
    check_flag("back_pressure_seen", 1'b1, ready_dropped);

    if (exp_addr.size() != 0)
    begin
      $display("%0d expected writebacks never arrived", exp_addr.size());
      end_with_failure();
    end
    else
    begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

/* test/decode_execute_properties.sv */
// Handshake and writeback assertions for the decode/execute slice
// Bound into decode_execute_top

module decode_execute_properties (
  input logic                                 clk,
  input logic                                 rst_n,
  input core_pkg::instr_u                     instr,
  input logic                                 instr_valid,
  input logic                                 instr_ready,
  input logic                                 wb_en,
  input logic [core_pkg::REG_INDEX_WIDTH-1:0] wb_addr
);

  timeunit 1ns;
  timeprecision 1ps;

  // Fetch side keeps the word steady until it is taken
  hold_instr: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_valid && !instr_ready) |=> $stable(instr))
    else $error("instr changed while instr_valid was high and instr_ready was low");

  // x0 destinations never reach the writeback port
  no_x0_writeback: assert property (@(posedge clk) disable iff (!rst_n)
    wb_en |-> (wb_addr != '0))
    else $error("wb_en was high with wb_addr equal to zero");

  // Pipe comes out of reset ready to accept
  ready_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> instr_ready)
    else $error("instr_ready was low in the first cycle after reset");

endmodule

bind decode_execute_top decode_execute_properties u_decode_execute_properties (
  .clk         (clk),
  .rst_n       (rst_n),
  .instr       (instr),
  .instr_valid (instr_valid),
  .instr_ready (instr_ready),
  .wb_en       (wb_en),
  .wb_addr     (wb_addr)
);

/* test/clock_gen.sv */
// Testbench clock source
// Free running clock with a 20 ns period, starts low

module clock_gen (
  output logic clk
);

  timeunit 1ns;
  timeprecision 1ps;

  // Half of the 20 ns period
  localparam int HALF_PERIOD = 10;

  initial
  begin
    clk = 1'b0;
    forever
      #HALF_PERIOD clk = ~clk;
  end

endmodule

/* hdl/decode_execute_top.sv */
// Decode/execute slice top level
// Control unit, register file, decode/execute register and execute unit

module decode_execute_top (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  core_pkg::instr_u                     instr,
  input  logic                                 instr_valid,
  output logic                                 instr_ready,
  output logic                                 wb_en,
  output logic [core_pkg::REG_INDEX_WIDTH-1:0] wb_addr,
  output logic [core_pkg::WORD_WIDTH-1:0]      wb_data
);

  // Decode side
  logic [core_pkg::ALU_OP_WIDTH-1:0]    alu_op;
  logic                                 alu_src;
  logic                                 reg_write;
  logic [core_pkg::WORD_WIDTH-1:0]      imm;
  logic                                 stall;
  logic                                 set_nop;
  logic [core_pkg::WORD_WIDTH-1:0]      rs1_data;
  logic [core_pkg::WORD_WIDTH-1:0]      rs2_data;

  // Pipeline register outputs
  logic [core_pkg::REG_INDEX_WIDTH-1:0] dx_rd;
  logic [core_pkg::WORD_WIDTH-1:0]      dx_rs1_data;
  logic [core_pkg::WORD_WIDTH-1:0]      dx_rs2_data;
  logic [core_pkg::WORD_WIDTH-1:0]      dx_imm;
  logic [core_pkg::ALU_OP_WIDTH-1:0]    dx_alu_op;
  logic                                 dx_alu_src;
  logic                                 dx_reg_write;
  logic                                 alu_op_done;

  control_unit u_control_unit (
    .instr        (instr),
    .instr_valid  (instr_valid),
    .dx_rd        (dx_rd),
    .dx_reg_write (dx_reg_write),
    .alu_op_done  (alu_op_done),
    .alu_op       (alu_op),
    .alu_src      (alu_src),
    .reg_write    (reg_write),
    .imm          (imm),
    .stall        (stall),
    .set_nop      (set_nop),
    .instr_ready  (instr_ready)
  );

  // Source fields sit at the same bits in both views
  register_file u_register_file (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (instr.r.rs1),
    .rs2_addr (instr.r.rs2),
    .wr_en    (wb_en),
    .wr_addr  (wb_addr),
    .wr_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // dx_instr left open, only kept for waveform debug
  decode_registers u_decode_registers (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr        (instr),
    .rd           (instr.r.rd),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .imm          (imm),
    .alu_op       (alu_op),
    .alu_src      (alu_src),
    .reg_write    (reg_write),
    .stall        (stall),
    .alu_op_done  (alu_op_done),
    .set_nop      (set_nop),
    .dx_instr     (),
    .dx_rd        (dx_rd),
    .dx_rs1_data  (dx_rs1_data),
    .dx_rs2_data  (dx_rs2_data),
    .dx_imm       (dx_imm),
    .dx_alu_op    (dx_alu_op),
    .dx_alu_src   (dx_alu_src),
    .dx_reg_write (dx_reg_write)
  );

  execute_unit u_execute_unit (
    .clk          (clk),
    .rst_n        (rst_n),
    .dx_rs1_data  (dx_rs1_data),
    .dx_rs2_data  (dx_rs2_data),
    .dx_imm       (dx_imm),
    .dx_alu_op    (dx_alu_op),
    .dx_alu_src   (dx_alu_src),
    .dx_reg_write (dx_reg_write),
    .dx_rd        (dx_rd),
    .alu_op_done  (alu_op_done),
    .wb_en        (wb_en),
    .wb_addr      (wb_addr),
    .wb_data      (wb_data)
  );

endmodule

/* hdl/execute_unit.sv */
// Execute unit
// Single-cycle ALU plus a multi-cycle multiplier, result goes to registered
// writeback outputs that also feed the register file write port

module execute_unit (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [core_pkg::WORD_WIDTH-1:0]      dx_rs1_data,
  input  logic [core_pkg::WORD_WIDTH-1:0]      dx_rs2_data,
  input  logic [core_pkg::WORD_WIDTH-1:0]      dx_imm,
  input  logic [core_pkg::ALU_OP_WIDTH-1:0]    dx_alu_op,
  input  logic                                 dx_alu_src,
  input  logic                                 dx_reg_write,
  input  logic [core_pkg::REG_INDEX_WIDTH-1:0] dx_rd,
  output logic                                 alu_op_done,
  output logic                                 wb_en,
  output logic [core_pkg::REG_INDEX_WIDTH-1:0] wb_addr,
  output logic [core_pkg::WORD_WIDTH-1:0]      wb_data
);

  logic [core_pkg::WORD_WIDTH-1:0]      operand_b;
  logic [core_pkg::WORD_WIDTH-1:0]      alu_result;
  logic [core_pkg::WORD_WIDTH-1:0]      mul_product;
  logic [core_pkg::MUL_COUNT_WIDTH-1:0] mul_count;
  logic                                 is_mul;
  logic                                 mul_last;

  // Immediate or register as second operand
  assign operand_b = dx_alu_src ? dx_imm : dx_rs2_data;

  // A squashed or non-writing MUL is not worth the wait
  assign is_mul   = dx_reg_write && (dx_alu_op == core_pkg::ALU_MUL);
  assign mul_last = (mul_count == core_pkg::MUL_LAST);

  // Low while the multiplier still counts, so decode_registers holds
  assign alu_op_done = !is_mul || mul_last;

  // Count 0 marks a fresh MUL since decode_registers moves on every done edge
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      mul_count <= '0;
    else if (is_mul && !mul_last)
      mul_count <= mul_count + 1'b1;
    else
      mul_count <= '0;
  end

  // Product captured on the first cycle, only the low word is kept
  always_ff @(posedge clk)
  begin
    if (is_mul && mul_count == '0)
      mul_product <= dx_rs1_data * dx_rs2_data;
  end

  always_comb
  begin
    case (dx_alu_op)
      core_pkg::ALU_ADD: alu_result = dx_rs1_data + operand_b;
      core_pkg::ALU_SUB: alu_result = dx_rs1_data - operand_b;
      core_pkg::ALU_AND: alu_result = dx_rs1_data & operand_b;
      core_pkg::ALU_OR:  alu_result = dx_rs1_data | operand_b;
      core_pkg::ALU_XOR: alu_result = dx_rs1_data ^ operand_b;
      core_pkg::ALU_MUL: alu_result = mul_product;
      default:           alu_result = '0;
    endcase
  end

  // One pulse per completed item, x0 destinations dropped
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_en   <= 1'b0;
      wb_addr <= '0;
    end
    else
    begin
      wb_en   <= alu_op_done && dx_reg_write && (dx_rd != '0);
      wb_addr <= dx_rd;
    end
  end

  always_ff @(posedge clk)
  begin
    if (alu_op_done)
      wb_data <= alu_result;
  end

endmodule

/* hdl/decode_registers.sv */
// Decode/execute pipeline register
// Advances when the execute unit is free and no hazard, holds otherwise,
// and loads a NOP bubble when asked to squash

module decode_registers (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [core_pkg::WORD_WIDTH-1:0]      instr,
  input  logic [core_pkg::REG_INDEX_WIDTH-1:0] rd,
  input  logic [core_pkg::WORD_WIDTH-1:0]      rs1_data,
  input  logic [core_pkg::WORD_WIDTH-1:0]      rs2_data,
  input  logic [core_pkg::WORD_WIDTH-1:0]      imm,
  input  logic [core_pkg::ALU_OP_WIDTH-1:0]    alu_op,
  input  logic                                 alu_src,
  input  logic                                 reg_write,
  input  logic                                 stall,
  input  logic                                 alu_op_done,
  input  logic                                 set_nop,
  output logic [core_pkg::WORD_WIDTH-1:0]      dx_instr,
  output logic [core_pkg::REG_INDEX_WIDTH-1:0] dx_rd,
  output logic [core_pkg::WORD_WIDTH-1:0]      dx_rs1_data,
  output logic [core_pkg::WORD_WIDTH-1:0]      dx_rs2_data,
  output logic [core_pkg::WORD_WIDTH-1:0]      dx_imm,
  output logic [core_pkg::ALU_OP_WIDTH-1:0]    dx_alu_op,
  output logic                                 dx_alu_src,
  output logic                                 dx_reg_write
);

  logic advance;

  // Plain load when nothing blocks the pipe
  assign advance = alu_op_done && !stall;

  // Control half, comes out of reset as a NOP
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      dx_instr     <= core_pkg::NOP_INSTRUCTION;
      dx_rd        <= '0;
      dx_reg_write <= 1'b0;
      dx_alu_op    <= core_pkg::ALU_ADD;
      dx_alu_src   <= 1'b0;
    end
    else if (set_nop)
    begin
      // Squash, ALU controls still follow the decoder
      dx_instr     <= core_pkg::NOP_INSTRUCTION;
      dx_rd        <= '0;
      dx_reg_write <= 1'b0;
      dx_alu_op    <= alu_op;
      dx_alu_src   <= alu_src;
    end
    else if (advance)
    begin
      dx_instr     <= instr;
      dx_rd        <= rd;
      dx_reg_write <= reg_write;
      dx_alu_op    <= alu_op;
      dx_alu_src   <= alu_src;
    end
  end

  // Operand half
  always_ff @(posedge clk)
  begin
    if (set_nop)
    begin
      dx_rs1_data <= '0;
      dx_rs2_data <= '0;
      dx_imm      <= imm;
    end
    else if (advance)
    begin
      dx_rs1_data <= rs1_data;
      dx_rs2_data <= rs2_data;
      dx_imm      <= imm;
    end
  end

endmodule

/* hdl/register_file.sv */
// Register file
// 32 x 32-bit, two asynchronous read ports and one write port
// x0 reads as zero, a same-cycle write is forwarded to the readers

module register_file (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [core_pkg::REG_INDEX_WIDTH-1:0] rs1_addr,
  input  logic [core_pkg::REG_INDEX_WIDTH-1:0] rs2_addr,
  input  logic                                 wr_en,
  input  logic [core_pkg::REG_INDEX_WIDTH-1:0] wr_addr,
  input  logic [core_pkg::WORD_WIDTH-1:0]      wr_data,
  output logic [core_pkg::WORD_WIDTH-1:0]      rs1_data,
  output logic [core_pkg::WORD_WIDTH-1:0]      rs2_data
);

  logic [core_pkg::WORD_WIDTH-1:0] regs [core_pkg::NUM_REGS];
  logic                            wr_live;

  // x0 is never written
  assign wr_live = wr_en && (wr_addr != '0);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < core_pkg::NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (wr_live)
    begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Bypass lets the reader see this cycle's writeback
  always_comb
  begin
    if (rs1_addr == '0)
      rs1_data = '0;
    else if (wr_live && wr_addr == rs1_addr)
      rs1_data = wr_data;
    else
      rs1_data = regs[rs1_addr];

    if (rs2_addr == '0)
      rs2_data = '0;
    else if (wr_live && wr_addr == rs2_addr)
      rs2_data = wr_data;
    else
      rs2_data = regs[rs2_addr];
  end

endmodule

/* hdl/control_unit.sv */
// Control unit
// Decodes the incoming word into ALU controls and immediate, detects RAW hazards
// against the decode/execute register and gates the upstream handshake

module control_unit (
  input  core_pkg::instr_u                        instr,
  input  logic                                    instr_valid,
  input  logic [core_pkg::REG_INDEX_WIDTH-1:0]    dx_rd,
  input  logic                                    dx_reg_write,
  input  logic                                    alu_op_done,
  output logic [core_pkg::ALU_OP_WIDTH-1:0]       alu_op,
  output logic                                    alu_src,
  output logic                                    reg_write,
  output logic [core_pkg::WORD_WIDTH-1:0]         imm,
  output logic                                    stall,
  output logic                                    set_nop,
  output logic                                    instr_ready
);

  logic known_op;
  logic uses_rs1;
  logic uses_rs2;
  logic rs1_hit;
  logic rs2_hit;

  // Sign extended I-type immediate, ignored by R-type through alu_src
  assign imm = {{(core_pkg::WORD_WIDTH - 12){instr.i.imm12[11]}}, instr.i.imm12};

  always_comb
  begin
    alu_op   = core_pkg::ALU_ADD;
    alu_src  = 1'b0;
    known_op = 1'b1;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (instr.r.opcode)
      core_pkg::OPCODE_OP:
      begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        // funct7 picks SUB or MUL, otherwise funct3 alone decides
        if (instr.r.funct7 == core_pkg::FUNCT7_MULDIV && instr.r.funct3 == core_pkg::FUNCT3_ADD)
          alu_op = core_pkg::ALU_MUL;
        else if (instr.r.funct7 == core_pkg::FUNCT7_SUB && instr.r.funct3 == core_pkg::FUNCT3_ADD)
          alu_op = core_pkg::ALU_SUB;
        else if (instr.r.funct3 == core_pkg::FUNCT3_AND)
          alu_op = core_pkg::ALU_AND;
        else if (instr.r.funct3 == core_pkg::FUNCT3_OR)
          alu_op = core_pkg::ALU_OR;
        else if (instr.r.funct3 == core_pkg::FUNCT3_XOR)
          alu_op = core_pkg::ALU_XOR;
        else if (instr.r.funct3 != core_pkg::FUNCT3_ADD)
          known_op = 1'b0;
      end
      core_pkg::OPCODE_OP_IMM:
      begin
        alu_src  = 1'b1;
        uses_rs1 = 1'b1;
        case (instr.i.funct3)
          core_pkg::FUNCT3_ADD: alu_op = core_pkg::ALU_ADD;
          core_pkg::FUNCT3_AND: alu_op = core_pkg::ALU_AND;
          core_pkg::FUNCT3_OR:  alu_op = core_pkg::ALU_OR;
          core_pkg::FUNCT3_XOR: alu_op = core_pkg::ALU_XOR;
          default:              known_op = 1'b0;
        endcase
      end
      // Anything else behaves as a NOP
      default: known_op = 1'b0;
    endcase
  end

  // Unknown or absent words never write
  assign reg_write = instr_valid && known_op;

  // RAW check against the item held in decode_registers
  assign rs1_hit = uses_rs1 && (instr.r.rs1 == dx_rd);
  assign rs2_hit = uses_rs2 && (instr.r.rs2 == dx_rd);
  assign stall   = instr_valid && known_op && dx_reg_write && (dx_rd != '0) && (rs1_hit || rs2_hit);

  // Bubble only when the pipeline would otherwise advance
  assign set_nop     = stall && alu_op_done;
  assign instr_ready = alu_op_done && !stall;

endmodule

/* hdl/core_pkg.sv */
// Core package for the decode/execute slice
// Word and index widths, RV32I encodings, ALU codes and the instruction union

package core_pkg;

  // Datapath and register file sizes
  localparam int WORD_WIDTH      = 32;
  localparam int REG_INDEX_WIDTH = 5;
  localparam int NUM_REGS        = 32;

  // Canonical NOP, ADDI x0, x0, 0
  localparam logic [WORD_WIDTH-1:0] NOP_INSTRUCTION = 32'h0000_0013;

  // Major opcodes
  localparam logic [6:0] OPCODE_OP     = 7'b011_0011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b001_0011;

  // funct3 codes, MUL shares the ADD code
  localparam logic [2:0] FUNCT3_ADD = 3'b000;
  localparam logic [2:0] FUNCT3_XOR = 3'b100;
  localparam logic [2:0] FUNCT3_OR  = 3'b110;
  localparam logic [2:0] FUNCT3_AND = 3'b111;

  // funct7 codes that pick SUB and the M extension
  localparam logic [6:0] FUNCT7_SUB    = 7'b010_0000;
  localparam logic [6:0] FUNCT7_MULDIV = 7'b000_0001;

  // ALU operation codes
  localparam int ALU_OP_WIDTH = 3;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_ADD = 3'd0;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SUB = 3'd1;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_AND = 3'd2;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_OR  = 3'd3;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_XOR = 3'd4;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_MUL = 3'd5;

  // Multiplier latency and its cycle counter
  localparam int MUL_CYCLES      = 4;
  localparam int MUL_COUNT_WIDTH = $clog2(MUL_CYCLES);
  localparam logic [MUL_COUNT_WIDTH-1:0] MUL_LAST = MUL_COUNT_WIDTH'(MUL_CYCLES - 1);

  // R-type layout
  typedef struct packed {
    logic [6:0]                 funct7;
    logic [REG_INDEX_WIDTH-1:0] rs2;
    logic [REG_INDEX_WIDTH-1:0] rs1;
    logic [2:0]                 funct3;
    logic [REG_INDEX_WIDTH-1:0] rd;
    logic [6:0]                 opcode;
  } r_type_t;

  // I-type layout
  typedef struct packed {
    logic [11:0]                imm12;
    logic [REG_INDEX_WIDTH-1:0] rs1;
    logic [2:0]                 funct3;
    logic [REG_INDEX_WIDTH-1:0] rd;
    logic [6:0]                 opcode;
  } i_type_t;

  // One instruction word, read raw or through either layout
  // rs1, funct3, rd and opcode sit at the same bits in both views
  typedef union packed {
    logic [WORD_WIDTH-1:0] word;
    r_type_t               r;
    i_type_t               i;
  } instr_u;

endpackage
